// File: Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - design/ex_pkg.sv
      - design/operand_forward.sv
      - design/branch_resolve.sv
      - design/muldiv_unit.sv
      - design/ex.sv
      - design/ex_mem_reg.sv
      - design/ex_top.sv
  - target: simulation
    files:
      - sim/ex_tb_clk.sv
      - sim/muldiv_chk.sv
      - sim/ex_tb.sv

// File: design/branch_resolve.sv
`timescale 1ns/10ps

module branch_resolve (
    input  ex_pkg::dispatch_ex_t    dispatch_i,
    input  logic [ex_pkg::XLEN-1:0] op1_i,
    input  logic [ex_pkg::XLEN-1:0] rs2_i,
    output ex_pkg::branch_t         branch_o
);

    always_comb begin
        branch_o.taken  = 1'b0;
        branch_o.target = dispatch_i.pc + dispatch_i.imm;
        case (dispatch_i.op)
            ex_pkg::B, ex_pkg::BL: begin
                branch_o.taken = 1'b1;
            end
            ex_pkg::JIRL: begin
                branch_o.taken  = 1'b1;
                branch_o.target = op1_i + dispatch_i.imm;
            end
            ex_pkg::BEQ: begin
                branch_o.taken = (op1_i == rs2_i);
            end
            ex_pkg::BNE: begin
                branch_o.taken = (op1_i != rs2_i);
            end
            ex_pkg::BLT: begin
                branch_o.taken = ($signed(op1_i) < $signed(rs2_i));
            end
            ex_pkg::BGE: begin
                branch_o.taken = ($signed(op1_i) >= $signed(rs2_i));
            end
            ex_pkg::BLTU: begin
                branch_o.taken = (op1_i < rs2_i);
            end
            ex_pkg::BGEU: begin
                branch_o.taken = (op1_i >= rs2_i);
            end
            default: begin
                branch_o.taken = 1'b0;
            end
        endcase
        if (!dispatch_i.valid) begin
            branch_o.taken = 1'b0;
        end
    end

endmodule

// File: design/ex.sv
`timescale 1ns/10ps

module ex (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  ex_pkg::dispatch_ex_t                 dispatch_i,
    input  ex_pkg::mem_fwd_t [ex_pkg::N_FWD-1:0] mem_fwd_i,
    output ex_pkg::ex_mem_t                      result_o,
    output ex_pkg::branch_t                      branch_o,
    output logic                                 stall_o
);

    logic [ex_pkg::XLEN-1:0]            op1;
    logic [ex_pkg::XLEN-1:0]            op2;
    logic [ex_pkg::XLEN-1:0]            rs2;
    logic [$clog2(ex_pkg::XLEN)-1:0]    shamt;
    logic [ex_pkg::XLEN-1:0]            logic_res;
    logic [ex_pkg::XLEN-1:0]            shift_res;
    logic [ex_pkg::XLEN-1:0]            arith_res;
    logic [ex_pkg::XLEN-1:0]            move_res;
    logic [ex_pkg::XLEN-1:0]            md_result;
    ex_pkg::res_class_e                 res_class;
    ex_pkg::muldiv_op_e                 md_op;
    ex_pkg::muldiv_req_t                md_req_data;
    ex_pkg::hs_state_e                  state;
    ex_pkg::hs_state_e                  state_next;
    logic                               is_md;
    logic                               md_req;
    logic                               md_ack;

    operand_forward u_fwd (
        .dispatch_i (dispatch_i),
        .mem_fwd_i  (mem_fwd_i),
        .op1_o      (op1),
        .op2_o      (op2),
        .rs2_o      (rs2)
    );

    branch_resolve u_branch (
        .dispatch_i (dispatch_i),
        .op1_i      (op1),
        .rs2_i      (rs2),
        .branch_o   (branch_o)
    );

    always_comb begin
        md_op = ex_pkg::MD_MUL;
        case (dispatch_i.op)
            ex_pkg::AND, ex_pkg::OR, ex_pkg::XOR, ex_pkg::NOR: res_class = ex_pkg::RES_LOGIC;
            ex_pkg::SLL, ex_pkg::SRL, ex_pkg::SRA:             res_class = ex_pkg::RES_SHIFT;
            ex_pkg::ADD, ex_pkg::SUB, ex_pkg::SLT, ex_pkg::SLTU: res_class = ex_pkg::RES_ARITH;
            ex_pkg::LUI, ex_pkg::PCADD:                        res_class = ex_pkg::RES_MOVE;
            ex_pkg::BL, ex_pkg::JIRL:                          res_class = ex_pkg::RES_JUMP;
            ex_pkg::MUL, ex_pkg::MULH, ex_pkg::MULHU, ex_pkg::DIV,
            ex_pkg::DIVU, ex_pkg::MOD, ex_pkg::MODU:           res_class = ex_pkg::RES_MULDIV;
            default:                                           res_class = ex_pkg::RES_NONE;
        endcase
        case (dispatch_i.op)
            ex_pkg::MULH:  md_op = ex_pkg::MD_MULH;
            ex_pkg::MULHU: md_op = ex_pkg::MD_MULHU;
            ex_pkg::DIV:   md_op = ex_pkg::MD_DIV;
            ex_pkg::DIVU:  md_op = ex_pkg::MD_DIVU;
            ex_pkg::MOD:   md_op = ex_pkg::MD_MOD;
            ex_pkg::MODU:  md_op = ex_pkg::MD_MODU;
            default:       md_op = ex_pkg::MD_MUL;
        endcase
    end

    assign shamt = op2[$clog2(ex_pkg::XLEN)-1:0];

    always_comb begin
        case (dispatch_i.op)
            ex_pkg::AND: logic_res = op1 & op2;
            ex_pkg::XOR: logic_res = op1 ^ op2;
            ex_pkg::NOR: logic_res = ~(op1 | op2);
            default:     logic_res = op1 | op2;
        endcase
        case (dispatch_i.op)
            ex_pkg::SRL: shift_res = op1 >> shamt;
            ex_pkg::SRA: shift_res = $signed(op1) >>> shamt;
            default:     shift_res = op1 << shamt;
        endcase
        case (dispatch_i.op)
            ex_pkg::SUB:  arith_res = op1 - op2;
            ex_pkg::SLT:  arith_res = {{(ex_pkg::XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            ex_pkg::SLTU: arith_res = {{(ex_pkg::XLEN-1){1'b0}}, op1 < op2};
            default:      arith_res = op1 + op2;
        endcase
        move_res = (dispatch_i.op == ex_pkg::LUI) ? op2 : dispatch_i.pc + op2;
    end

    assign is_md       = dispatch_i.valid && (res_class == ex_pkg::RES_MULDIV);
    assign md_req      = (state == ex_pkg::WAIT_ACK);
    assign md_req_data = '{op: md_op, a: op1, b: op2};

    muldiv_unit u_muldiv (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_i      (md_req),
        .req_data_i (md_req_data),
        .ack_o      (md_ack),
        .result_o   (md_result)
    );

    // Four-phase req/ack sequencing
    always_comb begin
        state_next = state;
        case (state)
            ex_pkg::IDLE:         if (is_md) state_next = ex_pkg::WAIT_ACK;
            ex_pkg::WAIT_ACK:     if (md_ack) state_next = ex_pkg::WAIT_RELEASE;
            ex_pkg::WAIT_RELEASE: if (!md_ack) state_next = is_md ? ex_pkg::WAIT_ACK : ex_pkg::IDLE;
            default:              state_next = ex_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= ex_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Released in the ack cycle so EX/MEM captures the product or quotient
    assign stall_o = is_md && !(state == ex_pkg::WAIT_ACK && md_ack);

    always_comb begin
        result_o.valid   = dispatch_i.valid && !stall_o;
        result_o.pc      = dispatch_i.pc;
        result_o.rd_addr = dispatch_i.rd_addr;
        result_o.rd_we   = dispatch_i.rd_we;
        case (res_class)
            ex_pkg::RES_LOGIC:  result_o.wdata = logic_res;
            ex_pkg::RES_SHIFT:  result_o.wdata = shift_res;
            ex_pkg::RES_ARITH:  result_o.wdata = arith_res;
            ex_pkg::RES_MOVE:   result_o.wdata = move_res;
            ex_pkg::RES_JUMP:   result_o.wdata = dispatch_i.pc + 32'd4;
            ex_pkg::RES_MULDIV: result_o.wdata = md_result;
            default:            result_o.wdata = '0;
        endcase
    end

endmodule

// File: design/ex_mem_reg.sv
`timescale 1ns/10ps

module ex_mem_reg (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            stall_i,
    input  ex_pkg::ex_mem_t result_i,
    output ex_pkg::ex_mem_t ex_mem_o
);

    logic            valid_q;
    ex_pkg::ex_mem_t data_q;

    // Stalled cycles become bubbles
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= result_i.valid && !stall_i;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= result_i;
    end

    always_comb begin
        ex_mem_o       = data_q;
        ex_mem_o.valid = valid_q;
    end

endmodule

// File: design/ex_pkg.sv
package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int N_FWD      = 2;

    typedef enum logic [5:0] {
        ADD, SUB, SLT, SLTU,
        AND, OR, XOR, NOR,
        SLL, SRL, SRA,
        LUI, PCADD,
        MUL, MULH, MULHU, DIV, DIVU, MOD, MODU,
        B, BL, JIRL, BEQ, BNE, BLT, BGE, BLTU, BGEU,
        NOP
    } alu_op_e;

    // Sub-ops of the iterative unit
    typedef enum logic [2:0] {
        MD_MUL, MD_MULH, MD_MULHU, MD_DIV, MD_DIVU, MD_MOD, MD_MODU
    } muldiv_op_e;

    typedef enum logic [2:0] {
        RES_LOGIC, RES_SHIFT, RES_ARITH, RES_MOVE, RES_JUMP, RES_MULDIV, RES_NONE
    } res_class_e;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_RELEASE
    } hs_state_e;

    typedef struct packed {
        logic                  valid;
        alu_op_e               op;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] src1_addr;
        logic [REG_ADDR_W-1:0] src2_addr;
        logic [XLEN-1:0]       src1_data;
        logic [XLEN-1:0]       src2_data;
        logic [XLEN-1:0]       imm;
        logic                  use_imm;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  rd_we;
    } dispatch_ex_t;

    typedef struct packed {
        logic                  we;
        logic                  is_load;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } mem_fwd_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  rd_we;
        logic [XLEN-1:0]       wdata;
    } ex_mem_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } branch_t;

    typedef struct packed {
        muldiv_op_e      op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } muldiv_req_t;

endpackage

// File: design/ex_top.sv
`timescale 1ns/10ps

module ex_top (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  ex_pkg::dispatch_ex_t                 dispatch_i,
    input  ex_pkg::mem_fwd_t [ex_pkg::N_FWD-1:0] mem_fwd_i,
    output ex_pkg::ex_mem_t                      ex_mem_o,
    output ex_pkg::branch_t                      branch_o,
    output logic                                 stall_o
);

    ex_pkg::ex_mem_t ex_result;

    ex u_ex (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .dispatch_i (dispatch_i),
        .mem_fwd_i  (mem_fwd_i),
        .result_o   (ex_result),
        .branch_o   (branch_o),
        .stall_o    (stall_o)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall_o),
        .result_i   (ex_result),
        .ex_mem_o   (ex_mem_o)
    );

endmodule

// File: design/muldiv_unit.sv
`timescale 1ns/10ps

module muldiv_unit (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    req_i,
    input  ex_pkg::muldiv_req_t     req_data_i,
    output logic                    ack_o,
    output logic [ex_pkg::XLEN-1:0] result_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_ACK
    } md_state_e;

    md_state_e                          state;
    ex_pkg::muldiv_op_e                 op_q;
    logic [2*ex_pkg::XLEN-1:0]          acc;
    logic [ex_pkg::XLEN-1:0]            opb;
    logic [ex_pkg::XLEN-1:0]            dividend;
    logic [$clog2(ex_pkg::XLEN)-1:0]    cnt;
    logic                               neg_q;
    logic                               b_zero;
    logic                               is_mul;
    logic                               is_signed;
    logic                               sign_a;
    logic                               sign_b;
    logic                               neg_in;
    logic [ex_pkg::XLEN-1:0]            abs_a;
    logic [ex_pkg::XLEN-1:0]            abs_b;
    logic [ex_pkg::XLEN:0]              mul_sum;
    logic [ex_pkg::XLEN+1:0]            div_diff;
    logic [2*ex_pkg::XLEN-1:0]          acc_neg;
    logic [ex_pkg::XLEN-1:0]            rem_neg;

    // Signed variants run on magnitudes, sign restored at the output
    assign is_signed = req_data_i.op inside {ex_pkg::MD_MULH, ex_pkg::MD_DIV, ex_pkg::MD_MOD};
    assign sign_a    = is_signed & req_data_i.a[ex_pkg::XLEN-1];
    assign sign_b    = is_signed & req_data_i.b[ex_pkg::XLEN-1];
    assign abs_a     = sign_a ? -req_data_i.a : req_data_i.a;
    assign abs_b     = sign_b ? -req_data_i.b : req_data_i.b;
    assign neg_in    = (req_data_i.op == ex_pkg::MD_MOD) ? sign_a : (sign_a ^ sign_b);

    assign is_mul   = op_q inside {ex_pkg::MD_MUL, ex_pkg::MD_MULH, ex_pkg::MD_MULHU};
    assign mul_sum  = {1'b0, acc[2*ex_pkg::XLEN-1:ex_pkg::XLEN]} + (acc[0] ? {1'b0, opb} : '0);
    // Trial subtract of divisor from {rem, next quotient bit}
    assign div_diff = {1'b0, acc[2*ex_pkg::XLEN-1:ex_pkg::XLEN-1]} - {2'b00, opb};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (req_i) state <= S_RUN;
                S_RUN:   if (cnt == '1) state <= S_ACK;
                S_ACK:   if (!req_i) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_i) begin
            op_q     <= req_data_i.op;
            acc      <= {{ex_pkg::XLEN{1'b0}}, abs_a};
            opb      <= abs_b;
            dividend <= req_data_i.a;
            neg_q    <= neg_in;
            b_zero   <= (req_data_i.b == '0);
            cnt      <= '0;
        end else if (state == S_RUN) begin
            cnt <= cnt + 1'b1;
            if (is_mul) begin
                acc <= {mul_sum, acc[ex_pkg::XLEN-1:1]};
            end else if (div_diff[ex_pkg::XLEN+1]) begin
                acc <= {acc[2*ex_pkg::XLEN-2:0], 1'b0};
            end else begin
                acc <= {div_diff[ex_pkg::XLEN-1:0], acc[ex_pkg::XLEN-2:0], 1'b1};
            end
        end
    end

    assign acc_neg = -acc;
    assign rem_neg = -acc[2*ex_pkg::XLEN-1:ex_pkg::XLEN];

    // Held stable in S_ACK since acc stops moving
    always_comb begin
        case (op_q)
            ex_pkg::MD_MUL:   result_o = acc[ex_pkg::XLEN-1:0];
            ex_pkg::MD_MULH:  result_o = neg_q ? acc_neg[2*ex_pkg::XLEN-1:ex_pkg::XLEN]
                                               : acc[2*ex_pkg::XLEN-1:ex_pkg::XLEN];
            ex_pkg::MD_MULHU: result_o = acc[2*ex_pkg::XLEN-1:ex_pkg::XLEN];
            ex_pkg::MD_DIV, ex_pkg::MD_DIVU:
                result_o = b_zero ? '1 : (neg_q ? acc_neg[ex_pkg::XLEN-1:0] : acc[ex_pkg::XLEN-1:0]);
            default:
                result_o = b_zero ? dividend
                                  : (neg_q ? rem_neg : acc[2*ex_pkg::XLEN-1:ex_pkg::XLEN]);
        endcase
    end

    assign ack_o = (state == S_ACK);

endmodule

// File: design/operand_forward.sv
`timescale 1ns/10ps

module operand_forward (
    input  ex_pkg::dispatch_ex_t                 dispatch_i,
    input  ex_pkg::mem_fwd_t [ex_pkg::N_FWD-1:0] mem_fwd_i,
    output logic [ex_pkg::XLEN-1:0]              op1_o,
    output logic [ex_pkg::XLEN-1:0]              op2_o,
    output logic [ex_pkg::XLEN-1:0]              rs2_o
);

    function automatic logic [ex_pkg::XLEN-1:0] fwd_value(
        input logic [ex_pkg::REG_ADDR_W-1:0]        addr,
        input logic [ex_pkg::XLEN-1:0]              data,
        input ex_pkg::mem_fwd_t [ex_pkg::N_FWD-1:0] slots
    );
        logic [ex_pkg::XLEN-1:0] value;
        value = data;
        // Ascending scan so the younger slot 1 overrides slot 0
        for (int i = 0; i < ex_pkg::N_FWD; i++) begin
            if (slots[i].we && slots[i].is_load && slots[i].addr == addr) begin
                value = slots[i].data;
            end
        end
        return value;
    endfunction

    assign op1_o = fwd_value(dispatch_i.src1_addr, dispatch_i.src1_data, mem_fwd_i);
    assign rs2_o = fwd_value(dispatch_i.src2_addr, dispatch_i.src2_data, mem_fwd_i);

    // Branch compares keep rs2, the ALU sees the immediate
    assign op2_o = dispatch_i.use_imm ? dispatch_i.imm : rs2_o;

endmodule

// File: sim/ex_tb.sv
`timescale 1ns/10ps

module ex_tb;

    localparam logic [31:0] PC0 = 32'h1c00_0100;

    typedef enum logic [1:0] {K_ALU, K_BR, K_LINK, K_MD} kind_e;

    typedef struct packed {
        kind_e                                kind;
        ex_pkg::alu_op_e                      op;
        logic [ex_pkg::XLEN-1:0]              s1;
        logic [ex_pkg::XLEN-1:0]              s2;
        logic [ex_pkg::XLEN-1:0]              imm;
        logic                                 use_imm;
        ex_pkg::mem_fwd_t [ex_pkg::N_FWD-1:0] fwd;
        logic                                 rnd_a;
        logic                                 rnd_b;
        logic                                 gap;
        logic [ex_pkg::XLEN-1:0]              exp_wdata;
        ex_pkg::branch_t                      exp_br;
    } row_t;

    logic                                 clk;
    logic                                 rst_n;
    ex_pkg::dispatch_ex_t                 dispatch;
    ex_pkg::mem_fwd_t [ex_pkg::N_FWD-1:0] mem_fwd;
    ex_pkg::ex_mem_t                      ex_mem;
    ex_pkg::branch_t                      branch;
    logic                                 stall;

    row_t        rows[$];
    logic [31:0] rand_state = 32'hadce624d;
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;
    int          ex_mem_errors = 0;
    int          branch_errors = 0;
    int          flag_errors = 0;
    int          assert_errors = 0;

    ex_tb_clk u_clk (
        .clk_o (clk)
    );

    ex_top DUT (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .dispatch_i (dispatch),
        .mem_fwd_i  (mem_fwd),
        .ex_mem_o   (ex_mem),
        .branch_o   (branch),
        .stall_o    (stall)
    );

    bind muldiv_unit muldiv_chk u_muldiv_chk (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .ack_i   (ack_o)
    );

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Reference for the iterative unit
    function automatic logic [31:0] muldiv_model(input ex_pkg::alu_op_e op,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        res;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'h0, a};
        ub = {32'h0, b};
        case (op)
            ex_pkg::MUL:   res = ua * ub;
            ex_pkg::MULH:  res = (sa * sb) >> 32;
            ex_pkg::MULHU: res = (ua * ub) >> 32;
            ex_pkg::DIV:   res = (b == 0) ? 64'shffff_ffff_ffff_ffff : sa / sb;
            ex_pkg::DIVU:  res = (b == 0) ? 64'hffff_ffff : ua / ub;
            ex_pkg::MOD:   res = (b == 0) ? sa : sa % sb;
            default:       res = (b == 0) ? ua : ua % ub;
        endcase
        return res[31:0];
    endfunction

    task automatic alu_row(input ex_pkg::alu_op_e op, input logic [31:0] s1, input logic [31:0] s2,
                           input logic [31:0] imm, input logic use_imm, input logic [31:0] exp);
        row_t r;
        r = '0;
        r.kind = K_ALU;
        r.op = op;
        r.s1 = s1;
        r.s2 = s2;
        r.imm = imm;
        r.use_imm = use_imm;
        r.exp_wdata = exp;
        rows.push_back(r);
    endtask

    task automatic br_row(input ex_pkg::alu_op_e op, input logic [31:0] s1, input logic [31:0] s2,
                          input logic [31:0] imm, input logic taken, input logic [31:0] target);
        row_t r;
        r = '0;
        r.kind = (op == ex_pkg::BL || op == ex_pkg::JIRL) ? K_LINK : K_BR;
        r.op = op;
        r.s1 = s1;
        r.s2 = s2;
        r.imm = imm;
        r.exp_wdata = PC0 + 32'd4;
        r.exp_br.taken = taken;
        r.exp_br.target = target;
        rows.push_back(r);
    endtask

    task automatic md_row(input ex_pkg::alu_op_e op, input logic [31:0] s1, input logic [31:0] s2,
                          input logic rnd_a, input logic rnd_b, input logic gap);
        row_t r;
        r = '0;
        r.kind = K_MD;
        r.op = op;
        r.s1 = s1;
        r.s2 = s2;
        r.rnd_a = rnd_a;
        r.rnd_b = rnd_b;
        r.gap = gap;
        rows.push_back(r);
    endtask

    // Adds a forwarding slot to the last row
    task automatic set_fwd(input int slot, input logic is_load, input logic [4:0] addr,
                           input logic [31:0] data);
        row_t r;
        r = rows.pop_back();
        r.fwd[slot].we = 1'b1;
        r.fwd[slot].is_load = is_load;
        r.fwd[slot].addr = addr;
        r.fwd[slot].data = data;
        rows.push_back(r);
    endtask

    task automatic build_table();
        alu_row(ex_pkg::ADD,   32'h0000_0005, 32'h0000_0007, 32'h0, 1'b0, 32'h0000_000c);
        alu_row(ex_pkg::ADD,   32'hffff_ffff, 32'h0000_0001, 32'h0, 1'b0, 32'h0000_0000);
        alu_row(ex_pkg::SUB,   32'h0000_0003, 32'h0000_0005, 32'h0, 1'b0, 32'hffff_fffe);
        alu_row(ex_pkg::AND,   32'hf0f0_f0f0, 32'hff00_ff00, 32'h0, 1'b0, 32'hf000_f000);
        alu_row(ex_pkg::OR,    32'hf0f0_0000, 32'h0000_0f0f, 32'h0, 1'b0, 32'hf0f0_0f0f);
        alu_row(ex_pkg::XOR,   32'haaaa_5555, 32'hffff_0000, 32'h0, 1'b0, 32'h5555_5555);
        alu_row(ex_pkg::NOR,   32'h0000_00ff, 32'h0000_ff00, 32'h0, 1'b0, 32'hffff_0000);
        alu_row(ex_pkg::SLL,   32'h0000_0001, 32'h0000_001f, 32'h0, 1'b0, 32'h8000_0000);
        alu_row(ex_pkg::SRL,   32'h8000_0000, 32'h0000_0004, 32'h0, 1'b0, 32'h0800_0000);
        alu_row(ex_pkg::SRA,   32'h8000_0000, 32'h0000_0004, 32'h0, 1'b0, 32'hf800_0000);
        alu_row(ex_pkg::SRA,   32'hffff_ff00, 32'h0000_0008, 32'h0, 1'b0, 32'hffff_ffff);
        alu_row(ex_pkg::SRA,   32'h8000_1234, 32'h0, 32'h0000_0001, 1'b1, 32'hc000_091a);
        alu_row(ex_pkg::SLT,   32'h8000_0000, 32'h7fff_ffff, 32'h0, 1'b0, 32'h0000_0001);
        alu_row(ex_pkg::SLTU,  32'h8000_0000, 32'h7fff_ffff, 32'h0, 1'b0, 32'h0000_0000);
        alu_row(ex_pkg::SLT,   32'hffff_ffff, 32'h0000_0000, 32'h0, 1'b0, 32'h0000_0001);
        alu_row(ex_pkg::SLTU,  32'hffff_ffff, 32'h0000_0000, 32'h0, 1'b0, 32'h0000_0000);
        alu_row(ex_pkg::SLT,   32'h0000_0005, 32'h0000_0005, 32'h0, 1'b0, 32'h0000_0000);
        alu_row(ex_pkg::LUI,   32'h0, 32'h0, 32'h1234_5000, 1'b1, 32'h1234_5000);
        alu_row(ex_pkg::PCADD, 32'h0, 32'h0, 32'h0000_2000, 1'b1, 32'h1c00_2100);
        alu_row(ex_pkg::ADD,   32'h0000_0064, 32'h0000_1234, 32'hffff_fffc, 1'b1, 32'h0000_0060);
        br_row(ex_pkg::B,    32'h0, 32'h0, 32'h0000_0040, 1'b1, 32'h1c00_0140);
        br_row(ex_pkg::BL,   32'h0, 32'h0, 32'hffff_fff0, 1'b1, 32'h1c00_00f0);
        br_row(ex_pkg::JIRL, 32'h0000_8000, 32'h0, 32'h0000_0010, 1'b1, 32'h0000_8010);
        br_row(ex_pkg::BEQ,  32'h0000_0005, 32'h0000_0005, 32'h0000_0040, 1'b1, 32'h1c00_0140);
        br_row(ex_pkg::BEQ,  32'h0000_0005, 32'h0000_0006, 32'h0000_0040, 1'b0, 32'h1c00_0140);
        br_row(ex_pkg::BNE,  32'h0000_0005, 32'h0000_0006, 32'h0000_0040, 1'b1, 32'h1c00_0140);
        br_row(ex_pkg::BLT,  32'h8000_0000, 32'h0000_0001, 32'h0000_0040, 1'b1, 32'h1c00_0140);
        br_row(ex_pkg::BLTU, 32'h8000_0000, 32'h0000_0001, 32'h0000_0040, 1'b0, 32'h1c00_0140);
        br_row(ex_pkg::BGE,  32'hffff_ffff, 32'h0000_0000, 32'h0000_0040, 1'b0, 32'h1c00_0140);
        br_row(ex_pkg::BGEU, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0040, 1'b1, 32'h1c00_0140);
        br_row(ex_pkg::BGE,  32'h7fff_ffff, 32'h7fff_ffff, 32'h0000_0040, 1'b1, 32'h1c00_0140);
        br_row(ex_pkg::BLTU, 32'h0000_0000, 32'hffff_ffff, 32'h0000_0040, 1'b1, 32'h1c00_0140);
        // Forwarding with sources at r1 and r2
        alu_row(ex_pkg::ADD, 32'd10, 32'd20, 32'h0, 1'b0, 32'd220);
        set_fwd(0, 1'b1, 5'd1, 32'd100);
        set_fwd(1, 1'b1, 5'd1, 32'd200);
        alu_row(ex_pkg::ADD, 32'd10, 32'd20, 32'h0, 1'b0, 32'd30);
        set_fwd(0, 1'b0, 5'd2, 32'd500);
        alu_row(ex_pkg::ADD, 32'd10, 32'd20, 32'h0, 1'b0, 32'd30);
        set_fwd(1, 1'b1, 5'd7, 32'd900);
        alu_row(ex_pkg::SUB, 32'd10, 32'd20, 32'h0, 1'b0, 32'd7);
        set_fwd(0, 1'b1, 5'd2, 32'd3);
        alu_row(ex_pkg::ADD, 32'd10, 32'd20, 32'd4, 1'b1, 32'd14);
        set_fwd(0, 1'b1, 5'd2, 32'd99);
        br_row(ex_pkg::BEQ, 32'd5, 32'd9, 32'h0000_0040, 1'b1, 32'h1c00_0140);
        set_fwd(1, 1'b1, 5'd2, 32'd5);
        md_row(ex_pkg::MUL,   32'h0, 32'h0, 1'b1, 1'b1, 1'b1);
        md_row(ex_pkg::MULH,  32'h0, 32'h0, 1'b1, 1'b1, 1'b1);
        md_row(ex_pkg::MULHU, 32'h0, 32'h0, 1'b1, 1'b1, 1'b1);
        md_row(ex_pkg::DIV,   32'h0, 32'h0, 1'b1, 1'b1, 1'b1);
        md_row(ex_pkg::DIVU,  32'h0, 32'h0, 1'b1, 1'b1, 1'b1);
        md_row(ex_pkg::MOD,   32'h0, 32'h0, 1'b1, 1'b1, 1'b1);
        md_row(ex_pkg::MODU,  32'h0, 32'h0, 1'b1, 1'b1, 1'b1);
        md_row(ex_pkg::DIV,   32'h0, 32'h0, 1'b1, 1'b0, 1'b1);
        md_row(ex_pkg::DIVU,  32'h0, 32'h0, 1'b1, 1'b0, 1'b1);
        md_row(ex_pkg::MOD,   32'h0, 32'h0, 1'b1, 1'b0, 1'b1);
        md_row(ex_pkg::MODU,  32'h0, 32'h0, 1'b1, 1'b0, 1'b1);
        md_row(ex_pkg::DIV,   32'hffff_fff9, 32'h0000_0002, 1'b0, 1'b0, 1'b1);
        md_row(ex_pkg::MOD,   32'hffff_fff9, 32'h0000_0002, 1'b0, 1'b0, 1'b1);
        md_row(ex_pkg::MULH,  32'h8000_0000, 32'h8000_0000, 1'b0, 1'b0, 1'b1);
        // Back to back multi-cycle ops then an ALU op right behind
        md_row(ex_pkg::MUL,   32'h0, 32'h0, 1'b1, 1'b1, 1'b0);
        md_row(ex_pkg::DIVU,  32'h0, 32'h0, 1'b1, 1'b1, 1'b0);
        md_row(ex_pkg::MOD,   32'h0, 32'h0, 1'b1, 1'b1, 1'b0);
        alu_row(ex_pkg::XOR, 32'h0000_00ff, 32'h0000_000f, 32'h0, 1'b0, 32'h0000_00f0);
    endtask

    task automatic check_ex_mem(input ex_pkg::ex_mem_t got, input ex_pkg::ex_mem_t exp,
                                input string what);
        if (got !== exp) begin
            ex_mem_errors++;
            $display("error at %0t: %s valid=%0b pc=%h rd=%0d wdata=%h, expected %0b %h %0d %h",
                     $time, what, got.valid, got.pc, got.rd_addr, got.wdata,
                     exp.valid, exp.pc, exp.rd_addr, exp.wdata);
        end
    endtask

    task automatic check_branch(input ex_pkg::branch_t got, input ex_pkg::branch_t exp,
                                input string what);
        if (got !== exp) begin
            branch_errors++;
            $display("error at %0t: %s branch taken=%0b target=%h, expected taken=%0b target=%h",
                     $time, what, got.taken, got.target, exp.taken, exp.target);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errors++;
            $display("error at %0t: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic apply_row(input int idx);
        row_t            r;
        ex_pkg::ex_mem_t exp;
        logic [31:0]     a;
        logic [31:0]     b;
        logic            saw_stall;
        string           what;
        r = rows[idx];
        a = r.rnd_a ? next_rand() : r.s1;
        b = r.rnd_b ? next_rand() : r.s2;
        if (r.kind == K_MD) begin
            r.exp_wdata = muldiv_model(r.op, a, b);
        end
        what = $sformatf("row %0d %s", idx, r.op.name());
        dispatch = '0;
        dispatch.valid = 1'b1;
        dispatch.op = r.op;
        dispatch.pc = PC0;
        dispatch.src1_addr = 5'd1;
        dispatch.src2_addr = 5'd2;
        dispatch.src1_data = a;
        dispatch.src2_data = b;
        dispatch.imm = r.imm;
        dispatch.use_imm = r.use_imm;
        dispatch.rd_addr = 5'(idx % 31 + 1);
        dispatch.rd_we = (r.kind != K_BR);
        mem_fwd = r.fwd;
        @(negedge clk);
        if (r.kind == K_BR || r.kind == K_LINK) begin
            check_branch(branch, r.exp_br, what);
        end
        saw_stall = 1'b0;
        while (stall) begin
            saw_stall = 1'b1;
            @(negedge clk);
            check_bit(ex_mem.valid, 1'b0, {what, " bubble valid"});
        end
        check_bit(saw_stall, r.kind == K_MD, {what, " stall seen"});
        @(posedge clk);
        #1;
        exp.valid = 1'b1;
        exp.pc = PC0;
        exp.rd_addr = dispatch.rd_addr;
        exp.rd_we = dispatch.rd_we;
        exp.wdata = r.exp_wdata;
        if (r.kind == K_BR) begin
            check_bit(ex_mem.valid, 1'b1, {what, " valid"});
        end else begin
            check_ex_mem(ex_mem, exp, what);
        end
        #1;
        if (r.gap) begin
            dispatch.valid = 1'b0;
            @(posedge clk);
            #1;
            check_bit(ex_mem.valid, 1'b0, {what, " second valid"});
            #1;
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run hung and was stopped after %0d cycles", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        dispatch = '0;
        mem_fwd = '0;
        build_table();
        cycle_limit = rows.size() * 40 + 100;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_bit(ex_mem.valid, 1'b0, "ex_mem valid after reset");
        check_bit(stall, 1'b0, "stall after reset");
        check_bit(branch.taken, 1'b0, "branch taken after reset");
        @(posedge clk);
        #2;
        foreach (rows[i]) begin
            apply_row(i);
        end
        dispatch = '0;
        @(posedge clk);
        assert_errors = DUT.u_ex.u_muldiv.u_muldiv_chk.fail_count;
        $display("Checks done: %0d ex_mem errors, %0d branch errors, %0d flag errors, %0d %s",
                 ex_mem_errors, branch_errors, flag_errors, assert_errors,
                 "assertion errors");
        if (ex_mem_errors + branch_errors + flag_errors + assert_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sim/ex_tb_clk.sv
`timescale 1ns/10ps

module ex_tb_clk (
    output logic clk_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
    end

    always #10 clk_o = ~clk_o;

endmodule

// File: sim/muldiv_chk.sv
`timescale 1ns/10ps

module muldiv_chk (
    input logic clk,
    input logic rst_n_i,
    input logic req_i,
    input logic ack_i
);

    // Failed assertions, read by the testbench at the end
    int fail_count = 0;

    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n_i) $rose(ack_i) |-> req_i
    ) else begin
        fail_count++;
        $error("ack rose without an open req");
    end

    req_held: assert property (
        @(posedge clk) disable iff (!rst_n_i) req_i && !ack_i |=> req_i
    ) else begin
        fail_count++;
        $error("req dropped before ack");
    end

    ack_held: assert property (
        @(posedge clk) disable iff (!rst_n_i) ack_i && req_i |=> ack_i
    ) else begin
        fail_count++;
        $error("ack dropped while req still high");
    end

    // New request only once the previous ack is gone
    req_after_release: assert property (
        @(posedge clk) disable iff (!rst_n_i) $rose(req_i) |-> !ack_i
    ) else begin
        fail_count++;
        $error("req rose while ack high");
    end

endmodule

// File: vlog.f
design/ex_pkg.sv
design/operand_forward.sv
design/branch_resolve.sv
design/muldiv_unit.sv
design/ex.sv
design/ex_mem_reg.sv
design/ex_top.sv
sim/ex_tb_clk.sv
sim/muldiv_chk.sv
sim/ex_tb.sv
